//--- logic/lsq_config.svh
// Sizing defines for the load/store queues and the data cache model
`ifndef LSQ_CONFIG_SVH
`define LSQ_CONFIG_SVH

// queue sizes, entries must be a power of two
`define LSQ_SQ_ENT       8
`define LSQ_SQ_IDX_W     3
`define LSQ_LQ_ENT       4
`define LSQ_LQ_IDX_W     2

// core-side tags
`define LSQ_ROB_IDX_W    5
`define LSQ_PRF_IDX_W    6
`define LSQ_BR_MASK_W    4

// memory side
`define LSQ_ADDR_W       16
`define LSQ_DC_LINES     16
`define LSQ_DC_MEM_WORDS 256
`define LSQ_DC_MISS_LAT  6

`endif

//--- logic/lsq_pkg.sv
// Queue pointer, tag and branch-mask types of the load/store queues
`default_nettype none
`include "lsq_config.svh"

package lsq_pkg;

	// store queue index and pointer with wrap bit
	typedef logic [`LSQ_SQ_IDX_W-1:0] sq_idx_t;
	typedef logic [`LSQ_SQ_IDX_W:0]   sq_ptr_t;

	// load queue pointer with wrap bit
	typedef logic [`LSQ_LQ_IDX_W:0]   lq_ptr_t;

	typedef logic [`LSQ_ROB_IDX_W-1:0] rob_idx_t;
	typedef logic [`LSQ_PRF_IDX_W-1:0] prf_tag_t;
	typedef logic [`LSQ_BR_MASK_W-1:0] br_mask_t;

	// missed load waiting for the miss register
	typedef enum logic {
		HOLD_IDLE,
		HOLD_BUSY
	} ld_hold_e;

endpackage

`default_nettype wire

//--- logic/mem_pkg.sv
// Address, data and cache line types of the memory side
`default_nettype none
`include "lsq_config.svh"

package mem_pkg;

	localparam int DC_IDX_W = $clog2(`LSQ_DC_LINES);

	typedef logic [`LSQ_ADDR_W-1:0] addr_t;
	typedef logic [63:0]            word_t;

	typedef enum logic {
		MISS_IDLE,
		MISS_WAIT
	} miss_e;

	// one word per line, tag is the address above the index
	typedef struct packed {
		logic                           valid;
		logic [`LSQ_ADDR_W-DC_IDX_W-1:0] tag;
		word_t                          data;
	} dc_line_t;

endpackage

`default_nettype wire

//--- logic/dcache_if.sv
// Queue to data cache signal bundle with one modport per side
`timescale 1ns/10ps
`default_nettype none

interface dcache_if;

	// load side
	logic           ld_en;
	mem_pkg::addr_t ld_addr;
	logic           hit;
	mem_pkg::word_t rd_data;
	logic           ld_ack;
	logic           stall;
	logic           mshr_vld;
	mem_pkg::addr_t mshr_addr;

	// store side
	logic           st_en;
	mem_pkg::addr_t st_addr;
	mem_pkg::word_t st_data;
	logic           st_ack;

	modport lq (
		output ld_en,
		output ld_addr,
		input  hit,
		input  rd_data,
		input  ld_ack,
		input  stall,
		input  mshr_vld,
		input  mshr_addr
	);

	modport sq (
		output st_en,
		output st_addr,
		output st_data,
		input  st_ack
	);

	modport dc (
		input  ld_en,
		input  ld_addr,
		output hit,
		output rd_data,
		output ld_ack,
		output stall,
		output mshr_vld,
		output mshr_addr,
		input  st_en,
		input  st_addr,
		input  st_data,
		output st_ack
	);

endinterface

`default_nettype wire

//--- logic/store_queue.sv
// Circular store queue with retire tracking, load issue gating and forwarding
`timescale 1ns/10ps
`default_nettype none
`include "lsq_config.svh"

module store_queue (
	input  logic             clk,
	input  logic             rst,
	input  logic             dp_st_i,
	input  logic             st_vld_i,
	input  lsq_pkg::sq_idx_t st_sq_idx_i,
	input  mem_pkg::addr_t   st_addr_i,
	input  mem_pkg::word_t   st_data_i,
	input  logic             st_retire_i,
	input  logic             br_recover_i,
	input  lsq_pkg::sq_ptr_t sq_tail_recovery_i,
	input  lsq_pkg::sq_idx_t rs_ld_pos_i,
	input  lsq_pkg::sq_idx_t ex_ld_pos_i,
	input  mem_pkg::addr_t   ld_addr_i,
	dcache_if.sq             dc,
	output logic             older_addr_known_o,
	output logic             fwd_vld_o,
	output mem_pkg::word_t   fwd_data_o,
	output lsq_pkg::sq_ptr_t sq_tail_o,
	output logic             sq_full_o
);

	mem_pkg::addr_t         st_addr_r [`LSQ_SQ_ENT];
	mem_pkg::word_t         st_data_r [`LSQ_SQ_ENT];
	logic [`LSQ_SQ_ENT-1:0] addr_vld_r;
	logic [`LSQ_SQ_ENT-1:0] addr_vld_nxt;
	logic [`LSQ_SQ_ENT-1:0] retire_rdy_r;
	logic [`LSQ_SQ_ENT-1:0] retire_rdy_nxt;
	lsq_pkg::sq_ptr_t       head_r;
	lsq_pkg::sq_ptr_t       retire_head_r;
	lsq_pkg::sq_ptr_t       tail_r;
	lsq_pkg::sq_idx_t       head_idx;
	logic                   st_write;
	logic [`LSQ_SQ_IDX_W:0] rs_older_cnt;
	logic [`LSQ_SQ_IDX_W:0] ex_older_cnt;

	// stores older than a load at position pos, a full queue wraps all the way round
	function automatic logic [`LSQ_SQ_IDX_W:0] older_cnt(input lsq_pkg::sq_idx_t pos,
			input lsq_pkg::sq_idx_t head, input logic full);
		older_cnt = {1'b0, lsq_pkg::sq_idx_t'(pos - head)};
		if (full && (pos == head))
			older_cnt = {1'b1, {`LSQ_SQ_IDX_W{1'b0}}};
	endfunction

	assign head_idx  = head_r[`LSQ_SQ_IDX_W-1:0];
	assign sq_full_o = ((head_r ^ tail_r) == {1'b1, {`LSQ_SQ_IDX_W{1'b0}}});
	assign sq_tail_o = tail_r;

	assign rs_older_cnt = older_cnt(rs_ld_pos_i, head_idx, sq_full_o);
	assign ex_older_cnt = older_cnt(ex_ld_pos_i, head_idx, sq_full_o);

	// ************************************************************************
	// cache write port
	// ************************************************************************

	// only retired stores go out, oldest first
	assign dc.st_en   = retire_rdy_r[head_idx];
	assign dc.st_addr = st_addr_r[head_idx];
	assign dc.st_data = st_data_r[head_idx];
	assign st_write   = dc.st_en && dc.st_ack;

	always_comb begin
		addr_vld_nxt   = addr_vld_r;
		retire_rdy_nxt = retire_rdy_r;
		if (dp_st_i)
			addr_vld_nxt[tail_r[`LSQ_SQ_IDX_W-1:0]] = 1'b0;
		if (st_vld_i)
			addr_vld_nxt[st_sq_idx_i] = 1'b1;
		if (st_retire_i)
			retire_rdy_nxt[retire_head_r[`LSQ_SQ_IDX_W-1:0]] = 1'b1;
		if (st_write) begin
			addr_vld_nxt[head_idx]   = 1'b0;
			retire_rdy_nxt[head_idx] = 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			head_r        <= '0;
			retire_head_r <= '0;
			tail_r        <= '0;
			addr_vld_r    <= '0;
			retire_rdy_r  <= '0;
		end else begin
			if (br_recover_i)
				tail_r <= sq_tail_recovery_i;
			else if (dp_st_i)
				tail_r <= tail_r + 1'b1;
			if (st_retire_i)
				retire_head_r <= retire_head_r + 1'b1;
			if (st_write)
				head_r <= head_r + 1'b1;
			addr_vld_r   <= addr_vld_nxt;
			retire_rdy_r <= retire_rdy_nxt;
		end
	end

	always_ff @(posedge clk) begin
		if (st_vld_i) begin
			st_addr_r[st_sq_idx_i] <= st_addr_i;
			st_data_r[st_sq_idx_i] <= st_data_i;
		end
	end

	// ************************************************************************
	// age checks for issue and execute
	// ************************************************************************

	always_comb begin
		lsq_pkg::sq_idx_t idx;
		older_addr_known_o = 1'b1;
		for (int k = 0; k < `LSQ_SQ_ENT; k++) begin
			idx = head_idx + lsq_pkg::sq_idx_t'(k);
			if ((k < rs_older_cnt) && !addr_vld_r[idx])
				older_addr_known_o = 1'b0;
		end
	end

	// walk from oldest to youngest so the last match wins
	always_comb begin
		lsq_pkg::sq_idx_t idx;
		fwd_vld_o  = 1'b0;
		fwd_data_o = '0;
		for (int k = 0; k < `LSQ_SQ_ENT; k++) begin
			idx = head_idx + lsq_pkg::sq_idx_t'(k);
			if ((k < ex_older_cnt) && addr_vld_r[idx] && (st_addr_r[idx] == ld_addr_i)) begin
				fwd_vld_o  = 1'b1;
				fwd_data_o = st_data_r[idx];
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/load_queue.sv
// Load hold register and circular miss queue with in-order completion
`timescale 1ns/10ps
`default_nettype none
`include "lsq_config.svh"

module load_queue (
	input  logic              clk,
	input  logic              rst,
	input  logic              ld_vld_i,
	input  mem_pkg::addr_t    ld_addr_i,
	input  lsq_pkg::rob_idx_t ld_rob_idx_i,
	input  lsq_pkg::prf_tag_t ld_dest_tag_i,
	input  lsq_pkg::br_mask_t ld_br_mask_i,
	input  logic              fwd_vld_i,
	input  mem_pkg::word_t    fwd_data_i,
	input  logic              older_addr_known_i,
	input  logic              br_recover_i,
	input  logic              br_correct_i,
	input  lsq_pkg::br_mask_t br_tag_fix_i,
	dcache_if.lq              dc,
	output logic              ld_iss_en_o,
	output logic              ld_done_o,
	output logic              lq_done_o,
	output mem_pkg::word_t    ld_data_o,
	output lsq_pkg::rob_idx_t ld_rob_idx_o,
	output lsq_pkg::prf_tag_t ld_dest_tag_o,
	output lsq_pkg::br_mask_t ld_br_mask_o
);

	lsq_pkg::ld_hold_e      hold_state_r;
	lsq_pkg::ld_hold_e      hold_state_nxt;
	mem_pkg::addr_t         hold_addr_r;
	lsq_pkg::rob_idx_t      hold_rob_r;
	lsq_pkg::prf_tag_t      hold_tag_r;
	lsq_pkg::br_mask_t      hold_mask_r;

	mem_pkg::addr_t         lq_addr_r [`LSQ_LQ_ENT];
	mem_pkg::word_t         lq_data_r [`LSQ_LQ_ENT];
	lsq_pkg::rob_idx_t      lq_rob_r [`LSQ_LQ_ENT];
	lsq_pkg::prf_tag_t      lq_tag_r [`LSQ_LQ_ENT];
	lsq_pkg::br_mask_t      lq_mask_r [`LSQ_LQ_ENT];
	lsq_pkg::br_mask_t      lq_mask_nxt [`LSQ_LQ_ENT];
	logic [`LSQ_LQ_ENT-1:0] lq_vld_r;
	logic [`LSQ_LQ_ENT-1:0] lq_vld_nxt;
	logic [`LSQ_LQ_ENT-1:0] lq_rdy_r;
	logic [`LSQ_LQ_ENT-1:0] lq_rdy_nxt;
	lsq_pkg::lq_ptr_t       head_r;
	lsq_pkg::lq_ptr_t       tail_r;
	logic [`LSQ_LQ_IDX_W-1:0] head_idx;
	logic [`LSQ_LQ_IDX_W-1:0] tail_idx;

	logic                   lq_empty;
	logic                   lq_full;
	logic                   hold_busy;
	logic                   hold_capture;
	logic                   ld_hit_done;
	logic                   need_mem;
	logic                   ld_miss;
	logic                   head_match;
	logic                   head_adv;
	mem_pkg::addr_t         alloc_addr;
	lsq_pkg::rob_idx_t      alloc_rob;
	lsq_pkg::prf_tag_t      alloc_tag;
	lsq_pkg::br_mask_t      alloc_mask;

	assign head_idx = head_r[`LSQ_LQ_IDX_W-1:0];
	assign tail_idx = tail_r[`LSQ_LQ_IDX_W-1:0];
	assign lq_empty = (head_r == tail_r);
	assign lq_full  = ((head_r ^ tail_r) == {1'b1, {`LSQ_LQ_IDX_W{1'b0}}});

	// ************************************************************************
	// load execute and miss request
	// ************************************************************************

	assign hold_busy  = (hold_state_r == lsq_pkg::HOLD_BUSY);
	assign alloc_addr = ld_vld_i ? ld_addr_i : hold_addr_r;
	assign alloc_rob  = ld_vld_i ? ld_rob_idx_i : hold_rob_r;
	assign alloc_tag  = ld_vld_i ? ld_dest_tag_i : hold_tag_r;
	assign alloc_mask = ld_vld_i ? ld_br_mask_i : hold_mask_r;

	// a returning miss owns the result bus
	assign ld_hit_done = ld_vld_i && (dc.hit || fwd_vld_i) && !dc.mshr_vld;
	assign need_mem    = ld_vld_i ? !ld_hit_done : hold_busy;

	assign dc.ld_en   = need_mem && !dc.mshr_vld && !lq_full;
	assign dc.ld_addr = alloc_addr;
	assign ld_miss    = dc.ld_en && dc.ld_ack;

	assign hold_capture = ld_vld_i && need_mem && !ld_miss;

	always_comb begin
		hold_state_nxt = hold_state_r;
		if (hold_capture)
			hold_state_nxt = lsq_pkg::HOLD_BUSY;
		else if (ld_miss || (br_recover_i && (|(hold_mask_r & br_tag_fix_i))))
			hold_state_nxt = lsq_pkg::HOLD_IDLE;
	end

	assign ld_iss_en_o = older_addr_known_i && !lq_full && !dc.stall &&
		(hold_state_nxt != lsq_pkg::HOLD_BUSY);

	always_ff @(posedge clk) begin
		if (hold_capture) begin
			hold_addr_r <= ld_addr_i;
			hold_rob_r  <= ld_rob_idx_i;
			hold_tag_r  <= ld_dest_tag_i;
			hold_mask_r <= ld_br_mask_i;
		end else if (br_correct_i) begin
			hold_mask_r <= hold_mask_r & ~br_tag_fix_i;
		end
	end

	// ************************************************************************
	// miss queue
	// ************************************************************************

	assign head_match = dc.mshr_vld && (lq_addr_r[head_idx] == dc.mshr_addr);

	// parked data waits if a new load completes this cycle
	assign lq_done_o = !lq_empty && lq_vld_r[head_idx] &&
		(head_match || (lq_rdy_r[head_idx] && !ld_hit_done));
	assign ld_done_o = ld_hit_done;

	// killed heads are skipped
	assign head_adv = !lq_empty && (lq_done_o || !lq_vld_r[head_idx]);

	always_comb begin
		lq_vld_nxt  = lq_vld_r;
		lq_rdy_nxt  = lq_rdy_r;
		lq_mask_nxt = lq_mask_r;
		if (ld_miss) begin
			lq_vld_nxt[tail_idx]  = 1'b1;
			lq_rdy_nxt[tail_idx]  = 1'b0;
			lq_mask_nxt[tail_idx] = alloc_mask;
		end
		for (int k = 0; k < `LSQ_LQ_ENT; k++) begin
			if (dc.mshr_vld && (lq_addr_r[k] == dc.mshr_addr))
				lq_rdy_nxt[k] = 1'b1;
			if (br_recover_i && (|(lq_mask_nxt[k] & br_tag_fix_i)))
				lq_vld_nxt[k] = 1'b0;
			else if (br_correct_i)
				lq_mask_nxt[k] = lq_mask_nxt[k] & ~br_tag_fix_i;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			hold_state_r <= lsq_pkg::HOLD_IDLE;
			head_r       <= '0;
			tail_r       <= '0;
			lq_vld_r     <= '0;
			lq_rdy_r     <= '0;
			lq_mask_r    <= '{default: '0};
		end else begin
			hold_state_r <= hold_state_nxt;
			if (head_adv)
				head_r <= head_r + 1'b1;
			if (ld_miss)
				tail_r <= tail_r + 1'b1;
			lq_vld_r  <= lq_vld_nxt;
			lq_rdy_r  <= lq_rdy_nxt;
			lq_mask_r <= lq_mask_nxt;
		end
	end

	always_ff @(posedge clk) begin
		if (ld_miss) begin
			lq_addr_r[tail_idx] <= alloc_addr;
			lq_rob_r[tail_idx]  <= alloc_rob;
			lq_tag_r[tail_idx]  <= alloc_tag;
		end
		for (int k = 0; k < `LSQ_LQ_ENT; k++)
			if (dc.mshr_vld && (lq_addr_r[k] == dc.mshr_addr))
				lq_data_r[k] <= dc.rd_data;
	end

	// ************************************************************************
	// result bus
	// ************************************************************************

	assign ld_data_o = lq_done_o ? (head_match ? dc.rd_data : lq_data_r[head_idx]) :
		(fwd_vld_i ? fwd_data_i : dc.rd_data);
	assign ld_rob_idx_o  = lq_done_o ? lq_rob_r[head_idx] : ld_rob_idx_i;
	assign ld_dest_tag_o = lq_done_o ? lq_tag_r[head_idx] : ld_dest_tag_i;
	assign ld_br_mask_o  = lq_done_o ? lq_mask_r[head_idx] : ld_br_mask_i;

endmodule

`default_nettype wire

//--- logic/dcache_model.sv
// Direct-mapped write-through data cache with one miss register
`timescale 1ns/10ps
`default_nettype none
`include "lsq_config.svh"

module dcache_model (
	input logic  clk,
	input logic  rst,
	dcache_if.dc dc
);

	localparam int MEM_IDX_W = $clog2(`LSQ_DC_MEM_WORDS);
	localparam int CNT_W     = $clog2(`LSQ_DC_MISS_LAT);

	mem_pkg::dc_line_t            lines_r [`LSQ_DC_LINES];
	mem_pkg::word_t               mem_r [`LSQ_DC_MEM_WORDS];
	mem_pkg::miss_e               state_r;
	mem_pkg::addr_t               miss_addr_r;
	logic [CNT_W-1:0]             cnt_r;
	logic [mem_pkg::DC_IDX_W-1:0] ld_li;
	logic [mem_pkg::DC_IDX_W-1:0] st_li;
	logic [mem_pkg::DC_IDX_W-1:0] miss_li;
	logic                         st_wr;
	logic                         st_line_hit;

	assign ld_li   = dc.ld_addr[mem_pkg::DC_IDX_W-1:0];
	assign st_li   = dc.st_addr[mem_pkg::DC_IDX_W-1:0];
	assign miss_li = miss_addr_r[mem_pkg::DC_IDX_W-1:0];

	// lookup
	assign dc.hit = lines_r[ld_li].valid &&
		(lines_r[ld_li].tag == dc.ld_addr[`LSQ_ADDR_W-1:mem_pkg::DC_IDX_W]);
	assign dc.rd_data = dc.mshr_vld ? mem_r[miss_addr_r[MEM_IDX_W-1:0]] :
		lines_r[ld_li].data;

	// miss register status
	assign dc.ld_ack    = (state_r == mem_pkg::MISS_IDLE);
	assign dc.stall     = (state_r == mem_pkg::MISS_WAIT);
	assign dc.mshr_vld  = (state_r == mem_pkg::MISS_WAIT) && (cnt_r == '0);
	assign dc.mshr_addr = miss_addr_r;

	// stores back off in the fill cycle
	assign dc.st_ack = !dc.mshr_vld;
	assign st_wr     = dc.st_en && dc.st_ack;
	assign st_line_hit = lines_r[st_li].valid &&
		(lines_r[st_li].tag == dc.st_addr[`LSQ_ADDR_W-1:mem_pkg::DC_IDX_W]);

	// ************************************************************************
	// miss FSM
	// ************************************************************************

	always_ff @(posedge clk) begin
		if (rst) begin
			state_r <= mem_pkg::MISS_IDLE;
			cnt_r   <= '0;
		end else begin
			case (state_r)
				mem_pkg::MISS_IDLE: begin
					if (dc.ld_en) begin
						state_r <= mem_pkg::MISS_WAIT;
						cnt_r   <= CNT_W'(`LSQ_DC_MISS_LAT - 1);
					end
				end
				mem_pkg::MISS_WAIT: begin
					if (cnt_r == '0)
						state_r <= mem_pkg::MISS_IDLE;
					else
						cnt_r <= cnt_r - 1'b1;
				end
				default: state_r <= mem_pkg::MISS_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (dc.ld_en && dc.ld_ack)
			miss_addr_r <= dc.ld_addr;
	end

	// ************************************************************************
	// lines and backing memory
	// ************************************************************************

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `LSQ_DC_LINES; i++)
				lines_r[i] <= '0;
			for (int i = 0; i < `LSQ_DC_MEM_WORDS; i++)
				mem_r[i] <= '0;
		end else begin
			if (st_wr) begin
				mem_r[dc.st_addr[MEM_IDX_W-1:0]] <= dc.st_data;
				if (st_line_hit)
					lines_r[st_li].data <= dc.st_data;
			end
			// fill with the current memory word
			if (dc.mshr_vld)
				lines_r[miss_li] <= {1'b1, miss_addr_r[`LSQ_ADDR_W-1:mem_pkg::DC_IDX_W],
					mem_r[miss_addr_r[MEM_IDX_W-1:0]]};
		end
	end

endmodule

`default_nettype wire

//--- logic/lsq_top.sv
// Load/store queue top with the store queue, load queue and data cache
`timescale 1ns/10ps
`default_nettype none

module lsq_top (
	input  logic              clk,
	input  logic              rst,
	input  logic              dp_st_i,
	input  logic              st_vld_i,
	input  lsq_pkg::sq_idx_t  st_sq_idx_i,
	input  mem_pkg::addr_t    st_addr_i,
	input  mem_pkg::word_t    st_data_i,
	input  logic              st_retire_i,
	input  logic              br_recover_i,
	input  lsq_pkg::sq_ptr_t  sq_tail_recovery_i,
	input  logic              br_correct_i,
	input  lsq_pkg::br_mask_t br_tag_fix_i,
	input  lsq_pkg::sq_idx_t  rs_ld_pos_i,
	input  lsq_pkg::sq_idx_t  ex_ld_pos_i,
	input  logic              ld_vld_i,
	input  mem_pkg::addr_t    ld_addr_i,
	input  lsq_pkg::rob_idx_t ld_rob_idx_i,
	input  lsq_pkg::prf_tag_t ld_dest_tag_i,
	input  lsq_pkg::br_mask_t ld_br_mask_i,
	output logic              ld_iss_en_o,
	output logic              ld_done_o,
	output logic              lq_done_o,
	output mem_pkg::word_t    ld_data_o,
	output lsq_pkg::rob_idx_t ld_rob_idx_o,
	output lsq_pkg::prf_tag_t ld_dest_tag_o,
	output lsq_pkg::br_mask_t ld_br_mask_o,
	output lsq_pkg::sq_ptr_t  sq_tail_o,
	output logic              sq_full_o
);

	logic           older_addr_known;
	logic           fwd_vld;
	mem_pkg::word_t fwd_data;

	dcache_if dc_bus ();

	store_queue sq_inst (
		.clk                (clk),
		.rst                (rst),
		.dp_st_i            (dp_st_i),
		.st_vld_i           (st_vld_i),
		.st_sq_idx_i        (st_sq_idx_i),
		.st_addr_i          (st_addr_i),
		.st_data_i          (st_data_i),
		.st_retire_i        (st_retire_i),
		.br_recover_i       (br_recover_i),
		.sq_tail_recovery_i (sq_tail_recovery_i),
		.rs_ld_pos_i        (rs_ld_pos_i),
		.ex_ld_pos_i        (ex_ld_pos_i),
		.ld_addr_i          (ld_addr_i),
		.dc                 (dc_bus),
		.older_addr_known_o (older_addr_known),
		.fwd_vld_o          (fwd_vld),
		.fwd_data_o         (fwd_data),
		.sq_tail_o          (sq_tail_o),
		.sq_full_o          (sq_full_o)
	);

	load_queue lq_inst (
		.clk                (clk),
		.rst                (rst),
		.ld_vld_i           (ld_vld_i),
		.ld_addr_i          (ld_addr_i),
		.ld_rob_idx_i       (ld_rob_idx_i),
		.ld_dest_tag_i      (ld_dest_tag_i),
		.ld_br_mask_i       (ld_br_mask_i),
		.fwd_vld_i          (fwd_vld),
		.fwd_data_i         (fwd_data),
		.older_addr_known_i (older_addr_known),
		.br_recover_i       (br_recover_i),
		.br_correct_i       (br_correct_i),
		.br_tag_fix_i       (br_tag_fix_i),
		.dc                 (dc_bus),
		.ld_iss_en_o        (ld_iss_en_o),
		.ld_done_o          (ld_done_o),
		.lq_done_o          (lq_done_o),
		.ld_data_o          (ld_data_o),
		.ld_rob_idx_o       (ld_rob_idx_o),
		.ld_dest_tag_o      (ld_dest_tag_o),
		.ld_br_mask_o       (ld_br_mask_o)
	);

	dcache_model dc_inst (
		.clk (clk),
		.rst (rst),
		.dc  (dc_bus)
	);

endmodule

`default_nettype wire

//--- tb/lsq_assert.sv
// Protocol assertions on the load/store queue top, bound into the DUT
`timescale 1ns/10ps
`default_nettype none

module lsq_assert (
	input logic clk,
	input logic rst,
	input logic dp_st_i,
	input logic sq_full_i,
	input logic ld_iss_en_i,
	input logic ld_done_i,
	input logic lq_done_i,
	input logic mshr_vld_i
);

	int fail_cnt = 0;

	// one result per cycle on the shared bus
	one_result: assert property (@(posedge clk) disable iff (rst) !(ld_done_i && lq_done_i))
	else begin
		$error("ld_done and lq_done high in the same cycle");
		fail_cnt++;
	end

	no_dispatch_full: assert property (@(posedge clk) disable iff (rst) !(dp_st_i && sq_full_i))
	else begin
		$error("store dispatched into a full store queue");
		fail_cnt++;
	end

	// state right after a reset cycle
	reset_outputs: assert property (@(posedge clk)
		rst |=> (!ld_done_i && !lq_done_i && !sq_full_i && ld_iss_en_i))
	else begin
		$error("outputs not in their reset state");
		fail_cnt++;
	end

	fill_owns_bus: assert property (@(posedge clk) disable iff (rst) mshr_vld_i |-> !ld_done_i)
	else begin
		$error("ld_done high during a miss return");
		fail_cnt++;
	end

endmodule

bind lsq_top lsq_assert lsq_assert_inst (
	.clk         (clk),
	.rst         (rst),
	.dp_st_i     (dp_st_i),
	.sq_full_i   (sq_full_o),
	.ld_iss_en_i (ld_iss_en_o),
	.ld_done_i   (ld_done_o),
	.lq_done_i   (lq_done_o),
	.mshr_vld_i  (dc_bus.mshr_vld)
);

`default_nettype wire

//--- tb/lsq_tb.sv
// Testbench for the load/store queue top with a reference memory and store queue
`timescale 1ns/10ps
`default_nettype none
`include "lsq_config.svh"

module lsq_tb;

	localparam int NUM_TESTS = 6;
	localparam int WAIT_MAX  = 40;
	localparam int SETTLE    = 2;
	localparam int ANY_PATH  = 0;
	localparam int FAST_PATH = 1;
	localparam int MISS_PATH = 2;

	logic              clk;
	logic              rst;
	logic              dp_st_i;
	logic              st_vld_i;
	lsq_pkg::sq_idx_t  st_sq_idx_i;
	mem_pkg::addr_t    st_addr_i;
	mem_pkg::word_t    st_data_i;
	logic              st_retire_i;
	logic              br_recover_i;
	lsq_pkg::sq_ptr_t  sq_tail_recovery_i;
	logic              br_correct_i;
	lsq_pkg::br_mask_t br_tag_fix_i;
	lsq_pkg::sq_idx_t  rs_ld_pos_i;
	lsq_pkg::sq_idx_t  ex_ld_pos_i;
	logic              ld_vld_i;
	mem_pkg::addr_t    ld_addr_i;
	lsq_pkg::rob_idx_t ld_rob_idx_i;
	lsq_pkg::prf_tag_t ld_dest_tag_i;
	lsq_pkg::br_mask_t ld_br_mask_i;
	logic              ld_iss_en_o;
	logic              ld_done_o;
	logic              lq_done_o;
	mem_pkg::word_t    ld_data_o;
	lsq_pkg::rob_idx_t ld_rob_idx_o;
	lsq_pkg::prf_tag_t ld_dest_tag_o;
	lsq_pkg::br_mask_t ld_br_mask_o;
	lsq_pkg::sq_ptr_t  sq_tail_o;
	logic              sq_full_o;

	// reference memory and store queue contents
	mem_pkg::word_t    model_mem [`LSQ_DC_MEM_WORDS];
	mem_pkg::addr_t    sq_addr [`LSQ_SQ_ENT];
	mem_pkg::word_t    sq_data [`LSQ_SQ_ENT];
	int unsigned       lcg_state;
	int                errors = 0;
	int                checks = 0;
	int                tests_done = 0;
	int                test_err0 = 0;

	lsq_top lsq_top_inst (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ************************************************************************
	// checks and helpers
	// ************************************************************************

	function automatic int unsigned lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic lsq_pkg::prf_tag_t tag_of(input lsq_pkg::rob_idx_t rob);
		return ~lsq_pkg::prf_tag_t'(rob);
	endfunction

	function automatic lsq_pkg::sq_idx_t tail_idx();
		return sq_tail_o[`LSQ_SQ_IDX_W-1:0];
	endfunction

	task automatic check_val(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		checks++;
		assert (got === exp)
		else begin
			$display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_cond(input logic ok, input string what);
		checks++;
		assert (ok === 1'b1)
		else begin
			$display("%0t %s", $time, what);
			errors++;
		end
	endtask

	task automatic report_test(input string name);
		tests_done++;
		$display("test %0d %s errors %0d", tests_done, name, errors - test_err0);
		test_err0 = errors;
	endtask

	// tail pointer follows dispatch and recovery one cycle later
	assert property (@(posedge clk) disable iff (rst)
		(dp_st_i && !br_recover_i) |=> (sq_tail_o == $past(sq_tail_o) + 1'b1))
	else begin
		$display("%0t sq_tail_o did not advance after a dispatch", $time);
		errors++;
	end

	assert property (@(posedge clk) disable iff (rst)
		br_recover_i |=> (sq_tail_o == $past(sq_tail_recovery_i)))
	else begin
		$display("%0t sq_tail_o did not take the recovery value", $time);
		errors++;
	end

	task automatic drive_idle();
		dp_st_i            = 1'b0;
		st_vld_i           = 1'b0;
		st_sq_idx_i        = '0;
		st_addr_i          = '0;
		st_data_i          = '0;
		st_retire_i        = 1'b0;
		br_recover_i       = 1'b0;
		sq_tail_recovery_i = '0;
		br_correct_i       = 1'b0;
		br_tag_fix_i       = '0;
		rs_ld_pos_i        = '0;
		ex_ld_pos_i        = '0;
		ld_vld_i           = 1'b0;
		ld_addr_i          = '0;
		ld_rob_idx_i       = '0;
		ld_dest_tag_i      = '0;
		ld_br_mask_i       = '0;
	endtask

	// ************************************************************************
	// core-side stimulus
	// ************************************************************************

	task automatic dispatch_store(output lsq_pkg::sq_idx_t idx);
		@(negedge clk);
		idx     = tail_idx();
		dp_st_i = 1'b1;
		@(negedge clk);
		dp_st_i = 1'b0;
	endtask

	task automatic fill_store(input lsq_pkg::sq_idx_t idx, input mem_pkg::addr_t a,
			input mem_pkg::word_t d);
		@(negedge clk);
		st_vld_i     = 1'b1;
		st_sq_idx_i  = idx;
		st_addr_i    = a;
		st_data_i    = d;
		sq_addr[idx] = a;
		sq_data[idx] = d;
		@(negedge clk);
		st_vld_i = 1'b0;
	endtask

	// retirement is in dispatch order
	task automatic retire_store(input lsq_pkg::sq_idx_t idx);
		@(negedge clk);
		st_retire_i               = 1'b1;
		model_mem[sq_addr[idx]] = sq_data[idx];
		@(negedge clk);
		st_retire_i = 1'b0;
	endtask

	task automatic recover_branch(input lsq_pkg::br_mask_t tag, input lsq_pkg::sq_ptr_t tail);
		@(negedge clk);
		br_recover_i       = 1'b1;
		br_tag_fix_i       = tag;
		sq_tail_recovery_i = tail;
		@(negedge clk);
		br_recover_i = 1'b0;
		br_tag_fix_i = '0;
	endtask

	task automatic correct_branch(input lsq_pkg::br_mask_t tag);
		@(negedge clk);
		br_correct_i = 1'b1;
		br_tag_fix_i = tag;
		@(negedge clk);
		br_correct_i = 1'b0;
		br_tag_fix_i = '0;
	endtask

	task automatic check_result(input mem_pkg::word_t d, input lsq_pkg::rob_idx_t rob,
			input lsq_pkg::br_mask_t mask);
		check_val("ld_data_o", ld_data_o, d);
		check_val("ld_rob_idx_o", ld_rob_idx_o, rob);
		check_val("ld_dest_tag_o", ld_dest_tag_o, tag_of(rob));
		check_val("ld_br_mask_o", ld_br_mask_o, mask);
	endtask

	// waits for issue permission, then sends the load for one cycle
	task automatic issue_load(input mem_pkg::addr_t a, input lsq_pkg::sq_idx_t pos,
			input lsq_pkg::rob_idx_t rob, input lsq_pkg::br_mask_t mask,
			input mem_pkg::word_t d, output logic fast);
		int n;
		n = 0;
		@(negedge clk);
		rs_ld_pos_i = pos;
		ex_ld_pos_i = pos;
		#SETTLE;
		while (!ld_iss_en_o && n < WAIT_MAX) begin
			@(negedge clk);
			#SETTLE;
			n++;
		end
		check_cond(ld_iss_en_o, "load was never allowed to issue");
		@(negedge clk);
		ld_vld_i      = 1'b1;
		ld_addr_i     = a;
		ld_rob_idx_i  = rob;
		ld_dest_tag_i = tag_of(rob);
		ld_br_mask_i  = mask;
		#SETTLE;
		fast = ld_done_o;
		if (fast)
			check_result(d, rob, mask);
		@(negedge clk);
		ld_vld_i = 1'b0;
	endtask

	task automatic wait_parked(input mem_pkg::word_t d, input lsq_pkg::rob_idx_t rob,
			input lsq_pkg::br_mask_t mask);
		int n;
		n = 0;
		#SETTLE;
		while (!lq_done_o && n < WAIT_MAX) begin
			@(negedge clk);
			#SETTLE;
			n++;
		end
		check_cond(lq_done_o, "parked load never completed");
		if (lq_done_o)
			check_result(d, rob, mask);
	endtask

	task automatic load_check(input mem_pkg::addr_t a, input lsq_pkg::sq_idx_t pos,
			input lsq_pkg::rob_idx_t rob, input lsq_pkg::br_mask_t mask,
			input mem_pkg::word_t d, input int mode);
		logic fast;
		issue_load(a, pos, rob, mask, d, fast);
		if (mode == FAST_PATH)
			check_cond(fast, "load did not complete in its issue cycle");
		else if (mode == MISS_PATH)
			check_cond(!fast, "load to an unwritten address did not miss");
		if (!fast)
			wait_parked(d, rob, mask);
	endtask

	// no completion may appear until the miss register frees up
	task automatic watch_killed();
		int n;
		n = 0;
		do begin
			@(negedge clk);
			#SETTLE;
			check_cond(!lq_done_o, "killed load produced lq_done_o");
			n++;
		end while (!ld_iss_en_o && n < WAIT_MAX);
		check_cond(ld_iss_en_o, "miss register never freed after a killed load");
	endtask

	// ************************************************************************
	// tests
	// ************************************************************************

	task automatic store_retire_reload();
		lsq_pkg::sq_idx_t idx [4];
		mem_pkg::addr_t   a;
		for (int k = 0; k < 4; k++)
			dispatch_store(idx[k]);
		// addresses and data arrive youngest first
		for (int k = 3; k >= 0; k--)
			fill_store(idx[k], mem_pkg::addr_t'(lcg_next() % 128), {lcg_next(), lcg_next()});
		for (int k = 0; k < 4; k++)
			retire_store(idx[k]);
		for (int k = 0; k < 4; k++) begin
			a = sq_addr[idx[k]];
			load_check(a, tail_idx(), lsq_pkg::rob_idx_t'(k), 4'b0000, model_mem[a], ANY_PATH);
			load_check(a, tail_idx(), lsq_pkg::rob_idx_t'(k + 8), 4'b0001, model_mem[a],
				ANY_PATH);
		end
	endtask

	task automatic forward_youngest();
		lsq_pkg::sq_idx_t older;
		lsq_pkg::sq_idx_t younger;
		mem_pkg::word_t   d_old;
		mem_pkg::word_t   d_new;
		d_old = {lcg_next(), lcg_next()};
		d_new = {lcg_next(), lcg_next()};
		dispatch_store(older);
		dispatch_store(younger);
		fill_store(younger, 16'd150, d_new);
		fill_store(older, 16'd150, d_old);
		load_check(16'd150, tail_idx(), 5'd10, 4'b0000, d_new, FAST_PATH);
		// only the older store is ahead of this position
		load_check(16'd150, younger, 5'd11, 4'b0000, d_old, FAST_PATH);
		retire_store(older);
		retire_store(younger);
	endtask

	task automatic gate_issue();
		lsq_pkg::sq_idx_t s;
		dispatch_store(s);
		@(negedge clk);
		rs_ld_pos_i = lsq_pkg::sq_idx_t'(s + 1);
		#SETTLE;
		check_val("ld_iss_en_o", ld_iss_en_o, 1'b0);
		@(negedge clk);
		rs_ld_pos_i = s;
		#SETTLE;
		check_val("ld_iss_en_o", ld_iss_en_o, 1'b1);
		fill_store(s, 16'd160, {lcg_next(), lcg_next()});
		@(negedge clk);
		rs_ld_pos_i = lsq_pkg::sq_idx_t'(s + 1);
		#SETTLE;
		check_val("ld_iss_en_o", ld_iss_en_o, 1'b1);
		retire_store(s);
	endtask

	task automatic miss_in_order();
		load_check(16'd200, tail_idx(), 5'd16, 4'b0000, model_mem[200], MISS_PATH);
		load_check(16'd201, tail_idx(), 5'd17, 4'b1000, model_mem[201], MISS_PATH);
	endtask

	task automatic fill_and_recover();
		lsq_pkg::sq_ptr_t t0;
		lsq_pkg::sq_idx_t idx;
		@(negedge clk);
		t0 = sq_tail_o;
		for (int k = 1; k <= `LSQ_SQ_ENT; k++) begin
			dispatch_store(idx);
			check_val("sq_tail_o", sq_tail_o, lsq_pkg::sq_ptr_t'(t0 + k));
			check_val("sq_full_o", sq_full_o, k == `LSQ_SQ_ENT);
		end
		recover_branch(4'b0000, t0);
		check_val("sq_tail_o", sq_tail_o, t0);
		check_val("sq_full_o", sq_full_o, 1'b0);
	endtask

	task automatic mask_kill_and_clear();
		logic             fast;
		lsq_pkg::sq_idx_t pos;
		pos = tail_idx();
		issue_load(16'd220, pos, 5'd20, 4'b0010, model_mem[220], fast);
		check_cond(!fast, "load to an unwritten address did not miss");
		recover_branch(4'b0010, sq_tail_o);
		watch_killed();
		issue_load(16'd230, pos, 5'd21, 4'b0101, model_mem[230], fast);
		check_cond(!fast, "load to an unwritten address did not miss");
		correct_branch(4'b0100);
		recover_branch(4'b0100, sq_tail_o);
		wait_parked(model_mem[230], 5'd21, 4'b0001);
	endtask

	initial begin
		rst = 1'b1;
		drive_idle();
		lcg_state = 24;
		for (int i = 0; i < `LSQ_DC_MEM_WORDS; i++)
			model_mem[i] = '0;
		repeat (8) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		store_retire_reload();
		report_test("store_retire_reload");
		forward_youngest();
		report_test("forward_youngest");
		gate_issue();
		report_test("gate_issue");
		miss_in_order();
		report_test("miss_in_order");
		fill_and_recover();
		report_test("fill_and_recover");
		mask_kill_and_clear();
		report_test("mask_kill_and_clear");
		repeat (2) @(negedge clk);
		$display("tests %0d checks %0d errors %0d assertion failures %0d", tests_done, checks,
			errors, lsq_top_inst.lsq_assert_inst.fail_cnt);
		if (errors == 0 && lsq_top_inst.lsq_assert_inst.fail_cnt == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	// watchdog
	initial begin
		repeat (NUM_TESTS * 400) @(posedge clk);
		$display("watchdog expired after %0d cycles", NUM_TESTS * 400);
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+logic
logic/lsq_pkg.sv
logic/mem_pkg.sv
logic/dcache_if.sv
logic/store_queue.sv
logic/load_queue.sv
logic/dcache_model.sv
logic/lsq_top.sv
tb/lsq_assert.sv
tb/lsq_tb.sv
